// ==== design/allocFsm.sv ====
`timescale 1ns/1ps

module allocFsm (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   update,
    input  logic [regAllocPkg::warpW-1:0]          updWarp,
    input  logic [2:0]                             updCount,
    input  logic [7:0]                             swWarpId,
    input  logic                                   exitStrobe,
    input  logic [regAllocPkg::warpW-1:0]          exitWarp,
    input  regAllocPkg::lutEntry_t [regAllocPkg::entriesPerWarp-1:0] exitEntries,
    output logic                                   lutWe,
    output logic [regAllocPkg::lutAddrW-1:0]       lutWAddr,
    output regAllocPkg::lutEntry_t                 lutWData,
    output logic                                   lutClr,
    output logic [regAllocPkg::warpW-1:0]          lutClrWarp,
    output logic                                   allocStall,
    output regAllocPkg::allocState_t               state,
    input  logic [regAllocPkg::warpW-1:0]          rdWarp,
    output logic [31:0]                            specialReg
);

    localparam int numSlots = 1 << regAllocPkg::slotW;
    localparam int numWarps = 1 << regAllocPkg::warpW;

    regAllocPkg::allocState_t nextState;

    logic [2:0]                      remaining;  // entries still to write
    logic [1:0]                      entryCnt;
    logic [regAllocPkg::warpW-1:0]   curWarp;
    logic [numSlots-1:0]             usedMap;    // 1 = slot taken
    logic [regAllocPkg::slotW-1:0]   lowFree;
    logic                            anyFree;
    logic [31:0]                     specRegs [numWarps];

    // lowest free slot, scanned from the top so the lowest index wins
    always_comb begin
        lowFree = '0;
        anyFree = 1'b0;
        for (int i = numSlots - 1; i >= 0; i--) begin
            if (!usedMap[i]) begin
                lowFree = i[regAllocPkg::slotW-1:0];
                anyFree = 1'b1;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            regAllocPkg::Ready: begin
                if (update && updCount != 3'd0) begin
                    nextState = regAllocPkg::Alloc;   // update beats exit
                end else if (exitStrobe) begin
                    nextState = regAllocPkg::Dealloc;
                end
            end
            regAllocPkg::Alloc: begin
                if (remaining == 3'd1) nextState = regAllocPkg::Ready;
            end
            regAllocPkg::Dealloc: nextState = regAllocPkg::Ready;
            default:              nextState = regAllocPkg::Ready;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= regAllocPkg::Ready;
            remaining <= '0;
            entryCnt  <= '0;
            curWarp   <= '0;
            usedMap   <= '0;
        end else begin
            state <= nextState;
            case (state)
                regAllocPkg::Ready: begin
                    if (update && updCount != 3'd0) begin
                        remaining <= updCount;
                        entryCnt  <= '0;
                        curWarp   <= updWarp;
                    end else if (exitStrobe) begin
                        curWarp <= exitWarp;
                    end
                end
                regAllocPkg::Alloc: begin
                    remaining <= remaining - 3'd1;
                    entryCnt  <= entryCnt + 2'd1;
                    if (anyFree) usedMap[lowFree] <= 1'b1;
                end
                regAllocPkg::Dealloc: begin
                    // release every slot the exiting warp still holds
                    for (int e = 0; e < regAllocPkg::entriesPerWarp; e++) begin
                        if (exitEntries[e].valid) begin
                            usedMap[{exitEntries[e].row, exitEntries[e].bankPair}] <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // software warp id, kept per hardware warp
    always_ff @(posedge clk) begin
        if (state == regAllocPkg::Ready && update && updCount != 3'd0) begin
            specRegs[updWarp] <= {24'd0, swWarpId};
        end
    end

    assign lutWe             = (state == regAllocPkg::Alloc);
    assign lutWAddr          = {curWarp, entryCnt};
    assign lutWData.valid    = anyFree;   // no slot left gives an invalid entry
    assign lutWData.row      = anyFree ? lowFree[3:1] : 3'd0;
    assign lutWData.bankPair = anyFree ? lowFree[0] : 1'b0;

    assign lutClr     = (state == regAllocPkg::Dealloc);
    assign lutClrWarp = curWarp;

    assign allocStall = (state == regAllocPkg::Alloc) || (state == regAllocPkg::Dealloc);
    assign specialReg = specRegs[rdWarp];

endmodule

// ==== design/operandMapper.sv ====
`timescale 1ns/1ps

module operandMapper (
    input  logic [regAllocPkg::warpW-1:0]          issueWarp,
    input  regAllocPkg::srcReq_t                   src1,
    input  regAllocPkg::srcReq_t                   src2,
    input  logic                                   wbValid,
    input  logic [regAllocPkg::warpW-1:0]          wbWarp,
    input  logic [2:0]                             wbReg,
    output logic [2:0][regAllocPkg::lutAddrW-1:0]  lutRdAddr,
    input  regAllocPkg::lutEntry_t [2:0]           lutRdData,
    input  logic [3:0]                             ocEmpty,
    output regAllocPkg::physAddr_t                 src1Addr,
    output regAllocPkg::physAddr_t                 src2Addr,
    output regAllocPkg::physAddr_t                 wbAddr,
    output logic                                   src1Valid,
    output logic                                   src2Valid,
    output logic                                   wbValidOut,
    output logic                                   bankConflict,
    output logic                                   sameSrc,
    output logic [2:0]                             src1Oc,
    output logic [2:0]                             src2Oc,
    input  logic [31:0]                            specialReg,
    output logic [1:0]                             speSlot,
    output logic [1:0]                             spe2Slot,
    output logic [255:0]                           speValue,
    output logic [255:0]                           spe2Value,
    input  regAllocPkg::issueBundle_t              inBundle,
    output regAllocPkg::issueBundle_t              outBundle,
    output logic [regAllocPkg::warpW-1:0]          outWarp
);

    logic [1:0] ocPick;

    // invalid entry maps to row 0, bank pair 0
    function automatic regAllocPkg::physAddr_t xlate(input regAllocPkg::lutEntry_t e,
                                                     input logic regBit0);
        regAllocPkg::physAddr_t a;
        a.row  = e.valid ? e.row : 3'd0;
        a.bank = {e.valid & e.bankPair, regBit0};
        return a;
    endfunction

    // entry index is reg bits 2:1, bit 0 picks the bank within the pair
    assign lutRdAddr[0] = {issueWarp, src1.regNum[2:1]};
    assign lutRdAddr[1] = {issueWarp, src2.regNum[2:1]};
    assign lutRdAddr[2] = {wbWarp, wbReg[2:1]};

    assign src1Addr   = xlate(lutRdData[0], src1.regNum[0]);
    assign src2Addr   = xlate(lutRdData[1], src2.regNum[0]);
    assign wbAddr     = xlate(lutRdData[2], wbReg[0]);
    assign src1Valid  = src1.valid;
    assign src2Valid  = src2.valid;
    assign wbValidOut = wbValid;

    assign bankConflict = src1.valid && src2.valid && (src1Addr.bank == src2Addr.bank);
    assign sameSrc      = src1.valid && src2.valid && (src1.regNum == src2.regNum);

    // lowest empty collector, 0 when all busy
    always_comb begin
        ocPick = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (ocEmpty[i]) ocPick = i[1:0];
        end
    end

    assign src1Oc = {ocPick, 1'b0};
    assign src2Oc = {ocPick, 1'b1};

    assign speSlot  = {src2.regNum[4], src1.regNum[4]};
    assign spe2Slot = {src2.regNum[3], src1.regNum[3]};
    assign speValue = {8{specialReg}};   // same warp id in every lane

    always_comb begin
        for (int l = 0; l < 8; l++) begin
            spe2Value[32*l +: 32] = l;   // lane index
        end
    end

    assign outBundle = inBundle;
    assign outWarp   = issueWarp;

endmodule

// ==== design/regAllocPkg.sv ====
package regAllocPkg;

    // geometry, fixed by the field widths below
    localparam int warpW          = 3;   // 8 hardware warps
    localparam int entriesPerWarp = 4;   // register-pair entries per warp
    localparam int slotW          = 4;   // 16 physical slots
    localparam int lutAddrW       = 5;   // warp + entry index

    typedef enum logic [1:0] {
        Ready   = 2'd0,
        Alloc   = 2'd1,
        Dealloc = 2'd2
    } allocState_t;

    typedef enum logic [3:0] {
        OpAdd = 4'd0,
        OpSub = 4'd1,
        OpAnd = 4'd2,
        OpOr  = 4'd3,
        OpXor = 4'd4,
        OpShl = 4'd5,
        OpShr = 4'd6,
        OpMul = 4'd7,
        OpMin = 4'd8,
        OpMax = 4'd9,
        OpMov = 4'd10    // 11..15 reserved
    } aluOp_t;

    // one LUT entry; {row, bankPair} is the slot number
    typedef struct packed {
        logic       valid;
        logic [2:0] row;
        logic       bankPair;
    } lutEntry_t;

    typedef struct packed {
        logic [2:0] row;
        logic [1:0] bank;   // {bankPair, reg bit 0}
    } physAddr_t;

    // bit 4 of regNum picks special value 1, bit 3 special value 2
    typedef struct packed {
        logic [4:0] regNum;
        logic       valid;
    } srcReq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [15:0] imm;
        logic        immValid;
        aluOp_t      aluOp;
        logic        memWrite;
        logic        memRead;
        logic        shared;
        logic        beq;
        logic        blt;
        logic [1:0]  scbId;
        logic [7:0]  activeMask;
        logic        regWrite;
        logic [4:0]  dst;
    } issueBundle_t;

endpackage

// ==== design/regAllocUnit.sv ====
`timescale 1ns/1ps

module regAllocUnit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  update,
    input  logic [regAllocPkg::warpW-1:0]         updWarp,
    input  logic [2:0]                            updCount,
    input  logic [7:0]                            swWarpId,
    input  logic                                  exitStrobe,
    input  logic [regAllocPkg::warpW-1:0]         exitWarp,
    output logic                                  allocStall,
    output regAllocPkg::allocState_t              state,
    input  logic [regAllocPkg::warpW-1:0]         issueWarp,
    input  regAllocPkg::srcReq_t                  src1,
    input  regAllocPkg::srcReq_t                  src2,
    input  logic                                  wbValid,
    input  logic [regAllocPkg::warpW-1:0]         wbWarp,
    input  logic [2:0]                            wbReg,
    input  logic [3:0]                            ocEmpty,
    output regAllocPkg::physAddr_t                src1Addr,
    output regAllocPkg::physAddr_t                src2Addr,
    output regAllocPkg::physAddr_t                wbAddr,
    output logic                                  src1Valid,
    output logic                                  src2Valid,
    output logic                                  wbValidOut,
    output logic                                  bankConflict,
    output logic                                  sameSrc,
    output logic [2:0]                            src1Oc,
    output logic [2:0]                            src2Oc,
    output logic [1:0]                            speSlot,
    output logic [1:0]                            spe2Slot,
    output logic [255:0]                          speValue,
    output logic [255:0]                          spe2Value,
    input  regAllocPkg::issueBundle_t             inBundle,
    output regAllocPkg::issueBundle_t             outBundle,
    output logic [regAllocPkg::warpW-1:0]         outWarp
);

    logic                                                    lutWe;
    logic [regAllocPkg::lutAddrW-1:0]                        lutWAddr;
    regAllocPkg::lutEntry_t                                  lutWData;
    logic                                                    lutClr;
    logic [regAllocPkg::warpW-1:0]                           lutClrWarp;
    regAllocPkg::lutEntry_t [regAllocPkg::entriesPerWarp-1:0] exitEntries;
    logic [2:0][regAllocPkg::lutAddrW-1:0]                   lutRdAddr;
    regAllocPkg::lutEntry_t [2:0]                            lutRdData;
    logic [31:0]                                             specialReg;

    allocFsm i_allocFsm (
        .clk         (clk),
        .rst         (rst),
        .update      (update),
        .updWarp     (updWarp),
        .updCount    (updCount),
        .swWarpId    (swWarpId),
        .exitStrobe  (exitStrobe),
        .exitWarp    (exitWarp),
        .exitEntries (exitEntries),
        .lutWe       (lutWe),
        .lutWAddr    (lutWAddr),
        .lutWData    (lutWData),
        .lutClr      (lutClr),
        .lutClrWarp  (lutClrWarp),
        .allocStall  (allocStall),
        .state       (state),
        .rdWarp      (issueWarp),   // special reg of the issuing warp
        .specialReg  (specialReg)
    );

    regLut i_regLut (
        .clk         (clk),
        .rst         (rst),
        .we          (lutWe),
        .wAddr       (lutWAddr),
        .wData       (lutWData),
        .clr         (lutClr),
        .clrWarp     (lutClrWarp),
        .rdAddr      (lutRdAddr),
        .rdData      (lutRdData),
        .exitEntries (exitEntries)
    );

    operandMapper i_operandMapper (
        .issueWarp    (issueWarp),
        .src1         (src1),
        .src2         (src2),
        .wbValid      (wbValid),
        .wbWarp       (wbWarp),
        .wbReg        (wbReg),
        .lutRdAddr    (lutRdAddr),
        .lutRdData    (lutRdData),
        .ocEmpty      (ocEmpty),
        .src1Addr     (src1Addr),
        .src2Addr     (src2Addr),
        .wbAddr       (wbAddr),
        .src1Valid    (src1Valid),
        .src2Valid    (src2Valid),
        .wbValidOut   (wbValidOut),
        .bankConflict (bankConflict),
        .sameSrc      (sameSrc),
        .src1Oc       (src1Oc),
        .src2Oc       (src2Oc),
        .specialReg   (specialReg),
        .speSlot      (speSlot),
        .spe2Slot     (spe2Slot),
        .speValue     (speValue),
        .spe2Value    (spe2Value),
        .inBundle     (inBundle),
        .outBundle    (outBundle),
        .outWarp      (outWarp)
    );

endmodule

// ==== design/regLut.sv ====
`timescale 1ns/1ps

module regLut (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           we,
    input  logic [regAllocPkg::lutAddrW-1:0]               wAddr,
    input  regAllocPkg::lutEntry_t                         wData,
    input  logic                                           clr,
    input  logic [regAllocPkg::warpW-1:0]                  clrWarp,
    input  logic [2:0][regAllocPkg::lutAddrW-1:0]          rdAddr,
    output regAllocPkg::lutEntry_t [2:0]                   rdData,
    output regAllocPkg::lutEntry_t [regAllocPkg::entriesPerWarp-1:0] exitEntries
);

    localparam int depth = 1 << regAllocPkg::lutAddrW;

    regAllocPkg::lutEntry_t table_q [depth];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < depth; i++) begin
                table_q[i] <= '0;
            end
        end else begin
            // whole warp cleared at once on exit
            if (clr) begin
                for (int e = 0; e < regAllocPkg::entriesPerWarp; e++) begin
                    table_q[{clrWarp, e[1:0]}] <= '0;
                end
            end
            if (we) table_q[wAddr] <= wData;
        end
    end

    // src1, src2, writeback
    always_comb begin
        for (int p = 0; p < 3; p++) begin
            rdData[p] = table_q[rdAddr[p]];
        end
    end

    always_comb begin
        for (int e = 0; e < regAllocPkg::entriesPerWarp; e++) begin
            exitEntries[e] = table_q[{clrWarp, e[1:0]}];
        end
    end

endmodule

// ==== regAlloc.f ====
design/regAllocPkg.sv
design/allocFsm.sv
design/regLut.sv
design/operandMapper.sv
design/regAllocUnit.sv
verif/tbClock.sv
verif/regAllocUnit_checker.sv
verif/regAllocTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f regAlloc.f --top-module regAllocTb -o regAllocSim

./obj_dir/regAllocSim 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== verif/regAllocTb.sv ====
`timescale 1ns/1ps

module regAllocTb;

    localparam int randomOps      = 300;
    localparam int watchdogCycles = 4 * (randomOps + 200);   // about 4x the needed cycles
    localparam int bundleW        = $bits(regAllocPkg::issueBundle_t);

    logic clk;
    logic rst;
    logic update;
    logic [2:0] updWarp;
    logic [2:0] updCount;
    logic [7:0] swWarpId;
    logic exitStrobe;
    logic [2:0] exitWarp;
    logic allocStall;
    regAllocPkg::allocState_t state;
    logic [2:0] issueWarp;
    regAllocPkg::srcReq_t src1, src2;
    logic wbValid;
    logic [2:0] wbWarp;
    logic [2:0] wbReg;
    logic [3:0] ocEmpty;
    regAllocPkg::physAddr_t src1Addr, src2Addr, wbAddr;
    logic src1Valid, src2Valid, wbValidOut, bankConflict, sameSrc;
    logic [2:0] src1Oc, src2Oc;
    logic [1:0] speSlot, spe2Slot;
    logic [255:0] speValue, spe2Value;
    regAllocPkg::issueBundle_t inBundle, outBundle;
    logic [2:0] outWarp;

    // reference model
    int          slotOf [8][4];   // -1 = invalid entry
    logic [15:0] usedModel;
    logic [7:0]  swIdModel [8];
    logic [7:0]  warpSeen;
    logic [31:0] lcgState = 32'h2899;
    int          mismatchCount = 0;
    int          otherCount = 0;

    tbClock i_tbClock (.clk(clk), .rst(rst));

    regAllocUnit i_regAllocUnit (.*);

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // slot number is row * 2 + bank pair
    function automatic logic [4:0] expAddr(input logic [2:0] w, input logic [4:0] r);
        int s;
        s = slotOf[w][r[2:1]];
        if (s < 0) begin
            return {4'd0, r[0]};
        end
        return {3'(s / 2), 1'(s % 2), r[0]};
    endfunction

    function automatic logic [255:0] laneIndices();
        logic [255:0] v;
        for (int l = 0; l < 8; l++) begin
            v[32*l +: 32] = 32'(l);
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [255:0] expected,
                           input logic [255:0] actual);
        assert (expected === actual) else begin
            mismatchCount++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic initInputs();
        update     <= 1'b0;
        updWarp    <= '0;
        updCount   <= '0;
        swWarpId   <= '0;
        exitStrobe <= 1'b0;
        exitWarp   <= '0;
        issueWarp  <= '0;
        src1       <= '0;
        src2       <= '0;
        wbValid    <= 1'b0;
        wbWarp     <= '0;
        wbReg      <= '0;
        ocEmpty    <= '0;
        inBundle   <= '0;
        usedModel = '0;
        warpSeen  = '0;
        for (int w = 0; w < 8; w++) begin
            for (int e = 0; e < 4; e++) begin
                slotOf[3'(w)][2'(e)] = -1;
            end
        end
    endtask

    task automatic expectStall(input string name, input int expected);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (allocStall && cycles < 16) begin
            cycles++;
            @(negedge clk);
        end
        assert (cycles < 16) else begin
            otherCount++;
            $display("%s: allocStall did not drop within 16 cycles", name);
        end
        assert (cycles == expected) else begin
            mismatchCount++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, cycles);
        end
    endtask

    task automatic allocWarp(input logic [2:0] w, input logic [2:0] n, input logic [7:0] id);
        int s;
        @(posedge clk);
        update   <= 1'b1;
        updWarp  <= w;
        updCount <= n;
        swWarpId <= id;
        @(posedge clk);
        update <= 1'b0;
        for (int k = 0; k < int'(n); k++) begin
            s = -1;
            for (int i = 0; i < 16; i++) begin
                if (s < 0 && !usedModel[4'(i)]) begin
                    s = i;   // lowest free slot
                end
            end
            slotOf[w][2'(k)] = s;
            if (s >= 0) begin
                usedModel[4'(s)] = 1'b1;
            end
        end
        if (n != 3'd0) begin
            swIdModel[w] = id;
            warpSeen[w]  = 1'b1;
        end
        expectStall("allocStall", int'(n));
    endtask

    task automatic retireWarp(input logic [2:0] w);
        @(posedge clk);
        exitStrobe <= 1'b1;
        exitWarp   <= w;
        @(posedge clk);
        exitStrobe <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (slotOf[w][2'(k)] >= 0) begin
                usedModel[4'(slotOf[w][2'(k)])] = 1'b0;
            end
            slotOf[w][2'(k)] = -1;
        end
        expectStall("deallocStall", 1);
    endtask

    task automatic driveIssue(input logic [2:0] w, input logic [4:0] r1, input logic v1,
                              input logic [4:0] r2, input logic v2, input logic wv,
                              input logic [3:0] oc, input regAllocPkg::issueBundle_t bundle);
        @(posedge clk);
        issueWarp <= w;
        src1      <= {r1, v1};
        src2      <= {r2, v2};
        wbValid   <= wv;
        wbWarp    <= w;
        wbReg     <= r1[2:0];
        ocEmpty   <= oc;
        inBundle  <= bundle;
        @(negedge clk);   // outputs settled
    endtask

    task automatic checkWarp(input logic [2:0] w);
        for (int r = 0; r < 8; r++) begin
            driveIssue(w, 5'(r), 1'b1, 5'(7 - r), 1'b1, 1'b1, 4'b0001, '0);
            compare("src1Addr", 256'(expAddr(w, 5'(r))), 256'(src1Addr));
            compare("src2Addr", 256'(expAddr(w, 5'(7 - r))), 256'(src2Addr));
            compare("wbAddr", 256'(expAddr(w, 5'(r))), 256'(wbAddr));
            if (warpSeen[w]) begin
                compare("speValue", {8{24'd0, swIdModel[w]}}, speValue);
            end
        end
    endtask

    task automatic randomIssue();
        logic [31:0] a;
        logic [95:0] bits;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [4:0]  addr1;
        logic [4:0]  addr2;
        logic [2:0]  w;
        logic [3:0]  oc;
        logic [1:0]  pick;
        logic        found;
        a    = lcgNext();
        bits = {lcgNext(), lcgNext(), lcgNext()};
        w    = a[10:8];
        r1   = a[20:16];
        r2   = (a[13:12] == 2'd0) ? r1 : a[26:22];   // hit sameSrc often
        oc   = a[31:28];
        driveIssue(w, r1, a[21], r2, a[27], a[14], oc, bits[bundleW-1:0]);
        addr1 = expAddr(w, r1);
        addr2 = expAddr(w, r2);
        pick  = 2'd0;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!found && oc[2'(i)]) begin
                pick  = 2'(i);
                found = 1'b1;
            end
        end
        compare("src1Valid", 256'(a[21]), 256'(src1Valid));
        compare("src2Valid", 256'(a[27]), 256'(src2Valid));
        compare("wbValidOut", 256'(a[14]), 256'(wbValidOut));
        compare("bankConflict", 256'(a[21] && a[27] && addr1[1:0] == addr2[1:0]),
                256'(bankConflict));
        compare("sameSrc", 256'(a[21] && a[27] && r1 == r2), 256'(sameSrc));
        compare("src1Oc", 256'({pick, 1'b0}), 256'(src1Oc));
        compare("src2Oc", 256'({pick, 1'b1}), 256'(src2Oc));
        compare("speSlot", 256'({r2[4], r1[4]}), 256'(speSlot));
        compare("spe2Slot", 256'({r2[3], r1[3]}), 256'(spe2Slot));
        compare("spe2Value", laneIndices(), spe2Value);
        compare("outBundle", 256'(bits[bundleW-1:0]), 256'(outBundle));
        compare("outWarp", 256'(w), 256'(outWarp));
        if (warpSeen[w]) begin
            compare("speValue", {8{24'd0, swIdModel[w]}}, speValue);
        end
    endtask

    initial begin
        initInputs();
        wait (rst === 1'b1);
        allocWarp(3'd0, 3'd3, 8'h40);
        allocWarp(3'd1, 3'd4, 8'h41);
        allocWarp(3'd2, 3'd2, 8'h42);
        allocWarp(3'd3, 3'd1, 8'h43);
        allocWarp(3'd4, 3'd0, 8'h44);   // count 0, no stall
        for (int w = 0; w < 4; w++) begin
            checkWarp(3'(w));
        end
        retireWarp(3'd1);
        allocWarp(3'd5, 3'd4, 8'h45);   // reuses the slots of warp 1
        checkWarp(3'd1);
        checkWarp(3'd5);
        allocWarp(3'd4, 3'd4, 8'h54);
        allocWarp(3'd6, 3'd4, 8'h56);
        allocWarp(3'd7, 3'd4, 8'h57);   // free map runs dry here
        for (int w = 4; w < 8; w++) begin
            checkWarp(3'(w));
        end
        for (int i = 0; i < randomOps; i++) begin
            randomIssue();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdogCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verif/regAllocUnit_checker.sv ====
`timescale 1ns/1ps

module regAllocUnit_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     update,
    input logic [2:0]               updCount,
    input logic                     exitStrobe,
    input logic                     allocStall,
    input regAllocPkg::allocState_t state
);

    logic startAlloc;

    assign startAlloc = update && (updCount != 3'd0);

    // FSM idle right after a reset cycle
    resetIdle: assert property (@(posedge clk)
        !rst |=> (state == regAllocPkg::Ready && !allocStall))
        else $error("state not Ready or allocStall high after reset");

    // an exit holds the stall for exactly one cycle
    exitStallOneCycle: assert property (@(posedge clk) disable iff (!rst)
        (state == regAllocPkg::Ready && exitStrobe && !startAlloc)
            |=> allocStall ##1 !allocStall)
        else $error("exit did not raise allocStall for exactly one cycle");

    updateStartsAlloc: assert property (@(posedge clk) disable iff (!rst)
        (state == regAllocPkg::Ready && startAlloc) |=> state == regAllocPkg::Alloc)
        else $error("update in Ready did not enter Alloc");

    // exit only counts without a competing update
    exitStartsDealloc: assert property (@(posedge clk) disable iff (!rst)
        (state == regAllocPkg::Ready && exitStrobe && !startAlloc)
            |=> state == regAllocPkg::Dealloc)
        else $error("exit in Ready did not enter Dealloc");

    deallocOneCycle: assert property (@(posedge clk) disable iff (!rst)
        state == regAllocPkg::Dealloc |=> state == regAllocPkg::Ready)
        else $error("Dealloc lasted more than one cycle");

endmodule

bind regAllocUnit regAllocUnit_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .update     (update),
    .updCount   (updCount),
    .exitStrobe (exitStrobe),
    .allocStall (allocStall),
    .state      (state)
);

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // low for the first 5 rising edges, released between edges
    initial begin
        rst = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule
